// File: src.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_arrays.sv
rtl/icache_lookup.sv
rtl/icache_replace.sv
rtl/icache_refill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
testbench/tb_icache.sv

// File: Makefile
TOP = tb_icache

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Simulation passed" sim.log

lint:
	verilator --lint-only -Irtl --top-module icache_top rtl/icache_pkg.sv \
		rtl/icache_arrays.sv rtl/icache_lookup.sv rtl/icache_replace.sv \
		rtl/icache_refill.sv rtl/icache_ctrl.sv rtl/icache_top.sv

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_icache.sv
// --------------------------------------------------------------------------
// Instruction cache testbench
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_config.svh"

module tb_icache;
    import icache_pkg::*;

    localparam int FETCHES = 42;
    localparam int LIMIT   = 16 + 2 * `ICACHE_SETS + FETCHES * 64;

    logic       clk_i;
    logic       rst_ni;
    logic       en_i;
    logic       flush_i;
    logic       miss_o;
    fetch_req_t fetch_req;
    fetch_rsp_t rsp;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    // scoreboard and counters
    logic [31:0] exp_q[$];
    logic [31:0] lfsr = 32'hc179;
    string       test_name = "boot";
    int          errors = 0;
    int          grants = 0;
    int          beats = 0;
    int          boot_cycles = 0;
    int          cycles = 0;
    logic        boot_done = 1'b0;

    icache_top dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .en_i        (en_i),
        .flush_i     (flush_i),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (rsp),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp),
        .miss_o      (miss_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // memory content rule
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    // six tags over two sets, so sets overflow the four ways
    function automatic logic [31:0] pool_addr();
        int tag;
        int set;
        int word;
        tag  = int'(rand_bits(3)) % 6;
        set  = int'(rand_bits(1));
        word = int'(rand_bits(2));
        return 32'h0001_0000 + 32'(tag * 256 + set * 16 + word * 4);
    endfunction

    // --------------------------------------------------------------------------
    // memory model with random grant delay and beat gaps
    // --------------------------------------------------------------------------
    initial begin : memory_model
        int          gnt_wait;
        int          gap;
        int          left;
        int          k;
        logic [31:0] line;
        gnt_wait = int'(rand_bits(2));
        gap  = 0;
        left = 0;
        k    = 0;
        line = '0;
        forever begin
            @(posedge clk_i);
            #1;
            mem_rsp.gnt    = 1'b0;
            mem_rsp.rvalid = 1'b0;
            if (left > 0) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    mem_rsp.rvalid = 1'b1;
                    mem_rsp.rdata  = mem_word(line + 32'(4 * k));
                    k++;
                    left--;
                    gap = int'(rand_bits(2));
                end
            end else if (mem_req.req) begin
                if (gnt_wait > 0) begin
                    gnt_wait--;
                end else begin
                    mem_rsp.gnt = 1'b1;
                    line     = mem_req.addr;
                    left     = `ICACHE_LINE_WORDS;
                    k        = 0;
                    gap      = int'(rand_bits(2));
                    gnt_wait = int'(rand_bits(2));
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // monitor, sampled at the falling edge where outputs are settled
    // --------------------------------------------------------------------------
    always @(negedge clk_i) begin
        logic [31:0] exp_addr;
        if (rst_ni) begin
            if (!boot_done) begin
                if (rsp.ready) begin
                    boot_done = 1'b1;
                    assert (boot_cycles == `ICACHE_SETS) else begin
                        errors++;
                        $display("mismatch boot expected %0d actual %0d",
                                 `ICACHE_SETS, boot_cycles);
                    end
                end else begin
                    boot_cycles++;
                end
            end
            // responses pop before this cycle's request is pushed
            if (rsp.valid) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("valid pulse with no fetch outstanding");
                end
                if (exp_q.size() > 0) begin
                    exp_addr = exp_q.pop_front();
                    assert (rsp.data == mem_word(exp_addr)) else begin
                        errors++;
                        $display("mismatch %s expected %h actual %h",
                                 test_name, mem_word(exp_addr), rsp.data);
                    end
                end
            end
            if (fetch_req.req && rsp.ready) begin
                exp_q.push_back(fetch_req.addr);
            end
            if (dut.i_refill.beat_o) begin
                beats++;
            end
            // earlier bursts must be complete at each new grant
            if (mem_req.req && mem_rsp.gnt) begin
                assert (beats == grants * `ICACHE_LINE_WORDS) else begin
                    errors++;
                    $display("mismatch %s expected %0d actual %0d", test_name,
                             grants * `ICACHE_LINE_WORDS, beats);
                end
                grants++;
            end
        end
    end

    // refill request holds with a stable address until granted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req.req && !mem_rsp.gnt) |=> (mem_req.req && $stable(mem_req.addr)))
    else begin
        errors++;
        $display("refill request dropped or moved before grant");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req.req |-> (mem_req.addr[`ICACHE_OFFSET_BITS-1:0] == '0))
    else begin
        errors++;
        $display("refill address is not line aligned");
    end

    // no miss pulse while the cache is off
    assert property (@(posedge clk_i) disable iff (!rst_ni) !en_i |-> !miss_o)
    else begin
        errors++;
        $display("miss pulse seen with the cache disabled");
    end

    // each refill follows a miss pulse exactly when the cache is on
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(mem_req.req) |-> ($past(miss_o) == $past(en_i)))
    else begin
        errors++;
        $display("refill started without the miss pulse the enable calls for");
    end

    assert property (@(posedge clk_i)
        !rst_ni |-> (!rsp.ready && !rsp.valid && !mem_req.req && !miss_o))
    else begin
        errors++;
        $display("outputs active during reset");
    end

    // hang guard
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------------------------------------------------------------
    // stimulus tasks
    // --------------------------------------------------------------------------

    // present a fetch until it is accepted
    task automatic issue(input logic [31:0] addr);
        logic taken;
        taken = 1'b0;
        fetch_req.req  = 1'b1;
        fetch_req.addr = addr;
        while (!taken) begin
            @(negedge clk_i);
            taken = rsp.ready;
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic fetch_one(input logic [31:0] addr);
        issue(addr);
        fetch_req.req = 1'b0;
        drain();
    endtask

    // line is cached, so valid comes next cycle with no refill
    task automatic hit_fetch(input logic [31:0] addr);
        issue(addr);
        fetch_req.req = 1'b0;
        @(negedge clk_i);
        assert (rsp.valid && !miss_o && !mem_req.req) else begin
            errors++;
            $display("fetch %h in %s did not hit in one cycle", addr, test_name);
        end
        drain();
    endtask

    task automatic refill_count(input logic [31:0] addr);
        int g0;
        g0 = grants;
        fetch_one(addr);
        assert (grants == g0 + 1) else begin
            errors++;
            $display("mismatch %s expected %0d actual %0d", test_name, g0 + 1, grants);
        end
    endtask

    initial begin
        rst_ni    = 1'b0;
        en_i      = 1'b1;
        flush_i   = 1'b0;
        fetch_req = '0;
        mem_rsp   = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        test_name = "hit";
        fetch_one(32'h0001_0020);
        hit_fetch(32'h0001_0024);
        hit_fetch(32'h0001_002c);

        // back-to-back fetches over overflowing sets
        test_name = "stream";
        for (int i = 0; i < 32; i++) begin
            issue(pool_addr());
        end
        fetch_req.req = 1'b0;
        drain();

        test_name = "cache_off";
        en_i = 1'b0;
        refill_count(32'h0001_0020);
        refill_count(32'h0001_0020);
        refill_count(pool_addr());
        refill_count(pool_addr());
        en_i = 1'b1;

        test_name = "flush";
        fetch_one(32'h0002_0040);
        hit_fetch(32'h0002_0044);
        flush_i = 1'b1;
        @(negedge clk_i);
        assert (!rsp.ready) else begin
            errors++;
            $display("fetch ready stayed high on a flush request");
        end
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        refill_count(32'h0002_0040);

        repeat (4) @(posedge clk_i);
        assert (boot_done && beats == grants * `ICACHE_LINE_WORDS) else begin
            errors++;
            $display("ready never rose or a refill burst was incomplete");
        end
        $display("checks done: %0d errors, %0d grants, %0d beats", errors, grants, beats);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rtl/icache_top.sv
// -------------------------------------------------------------------------
// Instruction cache top level
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_config.svh"

module icache_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   en_i,
    input  logic                   flush_i,
    input  icache_pkg::fetch_req_t fetch_req_i,
    output icache_pkg::fetch_rsp_t fetch_rsp_o,
    output icache_pkg::mem_req_t   mem_req_o,
    input  icache_pkg::mem_rsp_t   mem_rsp_i,
    output logic                   miss_o
);
    import icache_pkg::*;

    // array access and read data
    array_req_t                              array_req;
    tag_entry_t [`ICACHE_WAYS-1:0]           tag_rdata;
    logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_WORDS-1:0]
          [`ICACHE_WORD_WIDTH-1:0]           line_rdata;

    // lookup and replacement
    logic [`ICACHE_WAYS-1:0]                 hit;
    logic [`ICACHE_WORD_WIDTH-1:0]           hit_word;
    logic [`ICACHE_TAG_BITS-1:0]             cmp_tag;
    logic [$clog2(`ICACHE_LINE_WORDS)-1:0]   word_sel;
    logic [`ICACHE_WAYS-1:0]                 victim;
    logic                                    all_valid;
    logic                                    step;

    // refill handshake
    logic                                    start;
    logic [`ICACHE_ADDR_WIDTH-1:0]           line_addr;
    logic                                    beat;
    logic [$clog2(`ICACHE_LINE_WORDS)-1:0]   beat_idx;
    logic [`ICACHE_WORD_WIDTH-1:0]           beat_data;
    logic                                    done;

    icache_ctrl i_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .en_i        (en_i),
        .flush_i     (flush_i),
        .fetch_req_i (fetch_req_i),
        .fetch_rsp_o (fetch_rsp_o),
        .miss_o      (miss_o),
        .array_req_o (array_req),
        .hit_i       (hit),
        .hit_word_i  (hit_word),
        .victim_i    (victim),
        .all_valid_i (all_valid),
        .cmp_tag_o   (cmp_tag),
        .word_sel_o  (word_sel),
        .step_o      (step),
        .start_o     (start),
        .line_addr_o (line_addr),
        .beat_i      (beat),
        .beat_idx_i  (beat_idx),
        .beat_data_i (beat_data),
        .done_i      (done)
    );

    icache_arrays i_arrays (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .array_req_i  (array_req),
        .tag_rdata_o  (tag_rdata),
        .line_rdata_o (line_rdata)
    );

    icache_lookup i_lookup (
        .tag_rdata_i  (tag_rdata),
        .line_rdata_i (line_rdata),
        .cmp_tag_i    (cmp_tag),
        .word_sel_i   (word_sel),
        .hit_o        (hit),
        .hit_word_o   (hit_word)
    );

    icache_replace i_replace (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .tag_rdata_i (tag_rdata),
        .step_i      (step),
        .victim_o    (victim),
        .all_valid_o (all_valid)
    );

    icache_refill i_refill (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start),
        .line_addr_i (line_addr),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i),
        .beat_o      (beat),
        .beat_idx_o  (beat_idx),
        .beat_data_o (beat_data),
        .done_o      (done)
    );

endmodule

// File: rtl/icache_ctrl.sv
// -------------------------------------------------------------------------
// Instruction cache controller
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_config.svh"

module icache_ctrl (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  en_i,
    input  logic                                  flush_i,
    input  icache_pkg::fetch_req_t                fetch_req_i,
    output icache_pkg::fetch_rsp_t                fetch_rsp_o,
    output logic                                  miss_o,
    output icache_pkg::array_req_t                array_req_o,
    input  logic [`ICACHE_WAYS-1:0]               hit_i,
    input  logic [`ICACHE_WORD_WIDTH-1:0]         hit_word_i,
    input  logic [`ICACHE_WAYS-1:0]               victim_i,
    input  logic                                  all_valid_i,
    output logic [`ICACHE_TAG_BITS-1:0]           cmp_tag_o,
    output logic [$clog2(`ICACHE_LINE_WORDS)-1:0] word_sel_o,
    output logic                                  step_o,
    output logic                                  start_o,
    output logic [`ICACHE_ADDR_WIDTH-1:0]         line_addr_o,
    input  logic                                  beat_i,
    input  logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_idx_i,
    input  logic [`ICACHE_WORD_WIDTH-1:0]         beat_data_i,
    input  logic                                  done_i
);
    import icache_pkg::*;

    ctrl_state_e                    state_d, state_q;
    logic [`ICACHE_ADDR_WIDTH-1:0]  addr_d, addr_q;
    logic [`ICACHE_TAG_BITS-1:0]    tag_d, tag_q;
    logic [`ICACHE_WAYS-1:0]        evict_way_d, evict_way_q;
    logic [`ICACHE_INDEX_BITS-1:0]  flush_cnt_d, flush_cnt_q;
    logic                           flushing_d, flushing_q;
    logic                           can_accept;

    // a pending or incoming flush blocks new fetches
    assign can_accept = ~(flush_i | flushing_q);

    // after a refill the saved tag is compared
    assign cmp_tag_o   = (state_q == TAG_CMP_SAVED) ? tag_q
                                                    : addr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_BITS];
    assign word_sel_o  = addr_q[`ICACHE_OFFSET_BITS-1:2];
    assign line_addr_o = {addr_q[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_BITS],
                          {`ICACHE_OFFSET_BITS{1'b0}}};
    assign fetch_rsp_o.data = hit_word_i;

    // ---------------------------------------------------------------------
    // main FSM
    // ---------------------------------------------------------------------
    always_comb begin
        state_d     = state_q;
        addr_d      = addr_q;
        tag_d       = tag_q;
        evict_way_d = evict_way_q;
        flush_cnt_d = flush_cnt_q;
        flushing_d  = flushing_q;

        fetch_rsp_o.ready = 1'b0;
        fetch_rsp_o.valid = 1'b0;
        miss_o            = 1'b0;
        step_o            = 1'b0;
        start_o           = 1'b0;

        array_req_o       = '0;
        array_req_o.index = addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];

        case (state_q)
            // clear one set per cycle, all ways at once
            FLUSH: begin
                array_req_o.way_en = '1;
                array_req_o.we     = 1'b1;
                array_req_o.index  = flush_cnt_q;
                flush_cnt_d        = flush_cnt_q + 1'b1;
                if (int'(flush_cnt_q) == `ICACHE_SETS - 1) begin
                    flush_cnt_d = '0;
                    flushing_d  = 1'b0;
                    state_d     = IDLE;
                end
            end
            IDLE: begin
                fetch_rsp_o.ready = can_accept;
                if (!can_accept) begin
                    state_d = FLUSH;
                end
            end
            TAG_CMP, TAG_CMP_SAVED: begin
                // with the cache off only the redone lookup may hit
                if (|hit_i && (en_i || state_q == TAG_CMP_SAVED)) begin
                    fetch_rsp_o.valid = 1'b1;
                    fetch_rsp_o.ready = can_accept;
                    state_d           = IDLE;
                end else begin
                    state_d = REFILL;
                    start_o = 1'b1;
                    miss_o  = en_i;
                    tag_d   = addr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_BITS];
                    // cache off and hit: refresh the line in place
                    if (|hit_i) begin
                        evict_way_d = hit_i;
                    end else begin
                        evict_way_d = victim_i;
                        step_o      = all_valid_i;
                    end
                end
            end
            // write each beat into the victim way
            REFILL: begin
                if (beat_i) begin
                    array_req_o.way_en     = evict_way_q;
                    array_req_o.we         = 1'b1;
                    array_req_o.wtag.valid = 1'b1;
                    array_req_o.wtag.tag   = tag_q;
                    array_req_o.wdata      = beat_data_i;
                    array_req_o.woff       = beat_idx_i;
                end
                if (done_i) begin
                    state_d = REDO_REQ;
                end
            end
            // reread the freshly written set
            REDO_REQ: begin
                array_req_o.way_en = '1;
                state_d            = TAG_CMP_SAVED;
            end
            default: state_d = IDLE;
        endcase

        // accepted fetch starts the array read right away
        if (fetch_rsp_o.ready && fetch_req_i.req) begin
            addr_d             = fetch_req_i.addr;
            array_req_o.way_en = '1;
            array_req_o.index  = fetch_req_i.addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
            state_d            = TAG_CMP;
        end

        // flush request is latched until the next IDLE
        if (flush_i) begin
            flushing_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= FLUSH;
            evict_way_q <= '0;
            flush_cnt_q <= '0;
            flushing_q  <= 1'b0;
        end else begin
            state_q     <= state_d;
            evict_way_q <= evict_way_d;
            flush_cnt_q <= flush_cnt_d;
            flushing_q  <= flushing_d;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
        tag_q  <= tag_d;
    end

endmodule

// File: rtl/icache_refill.sv
// -------------------------------------------------------------------------
// Line refill sequencer
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_config.svh"

module icache_refill (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  start_i,
    input  logic [`ICACHE_ADDR_WIDTH-1:0]         line_addr_i,
    output icache_pkg::mem_req_t                  mem_req_o,
    input  icache_pkg::mem_rsp_t                  mem_rsp_i,
    output logic                                  beat_o,
    output logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_idx_o,
    output logic [`ICACHE_WORD_WIDTH-1:0]         beat_data_o,
    output logic                                  done_o
);

    // request pending, then beats outstanding
    logic                                  req_q;
    logic                                  busy_q;
    logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_cnt_q;

    // the controller holds the line address stable for the whole refill
    assign mem_req_o.req  = req_q;
    assign mem_req_o.addr = line_addr_i;

    // beats only count after the grant cycle
    assign beat_o      = busy_q & mem_rsp_i.rvalid;
    assign beat_idx_o  = beat_cnt_q;
    assign beat_data_o = mem_rsp_i.rdata;
    assign done_o      = beat_o && (int'(beat_cnt_q) == `ICACHE_LINE_WORDS - 1);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q      <= 1'b0;
            busy_q     <= 1'b0;
            beat_cnt_q <= '0;
        end else begin
            if (start_i) begin
                req_q <= 1'b1;
            end else if (req_q && mem_rsp_i.gnt) begin
                // granted, drop the request and wait for data
                req_q      <= 1'b0;
                busy_q     <= 1'b1;
                beat_cnt_q <= '0;
            end
            if (beat_o) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
            if (done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/icache_replace.sv
// -------------------------------------------------------------------------
// Victim way selection
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_config.svh"

module icache_replace (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0] tag_rdata_i,
    input  logic                                      step_i,
    output logic [`ICACHE_WAYS-1:0]                   victim_o,
    output logic                                      all_valid_o
);

    logic [`ICACHE_WAYS-1:0] invalid;
    logic [7:0]              lfsr_q;

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_valid
        assign invalid[w] = ~tag_rdata_i[w].valid;
    end

    assign all_valid_o = ~|invalid;

    // ---------------------------------------------------------------------
    // random pick, 8-bit Galois LFSR
    // ---------------------------------------------------------------------

    // taps for x^8 + x^6 + x^5 + x^4 + 1, never reaches zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q <= 8'h01;
        end else if (step_i) begin
            lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hb8 : 8'h00);
        end
    end

    always_comb begin
        victim_o = '0;
        if (all_valid_o) begin
            // low LFSR bits decoded to one-hot
            victim_o[lfsr_q[$clog2(`ICACHE_WAYS)-1:0]] = 1'b1;
        end else begin
            // isolate the lowest set bit: lowest invalid way
            victim_o = invalid & (~invalid + 1'b1);
        end
    end

endmodule

// File: rtl/icache_lookup.sv
// -------------------------------------------------------------------------
// Tag compare and way select
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_config.svh"

module icache_lookup (
    input  icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]    tag_rdata_i,
    input  logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_WORDS-1:0]
                 [`ICACHE_WORD_WIDTH-1:0]                line_rdata_i,
    input  logic [`ICACHE_TAG_BITS-1:0]                  cmp_tag_i,
    input  logic [$clog2(`ICACHE_LINE_WORDS)-1:0]        word_sel_i,
    output logic [`ICACHE_WAYS-1:0]                      hit_o,
    output logic [`ICACHE_WORD_WIDTH-1:0]                hit_word_o
);

    // a way hits on a valid entry with a matching tag
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_cmp
        assign hit_o[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == cmp_tag_i);
    end

    // ---------------------------------------------------------------------
    // word select
    // ---------------------------------------------------------------------

    // at most one way hits, so an OR of the masked words is enough
    always_comb begin
        hit_word_o = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_o[w]) begin
                hit_word_o |= line_rdata_i[w][word_sel_i];
            end
        end
    end

endmodule

// File: rtl/icache_arrays.sv
// -------------------------------------------------------------------------
// Tag and data arrays
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_config.svh"

module icache_arrays (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  icache_pkg::array_req_t                       array_req_i,
    output icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]    tag_rdata_o,
    output logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_WORDS-1:0]
                 [`ICACHE_WORD_WIDTH-1:0]                line_rdata_o
);
    import icache_pkg::*;

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        // one tag entry and one line per set
        tag_entry_t                    tag_mem  [`ICACHE_SETS];
        logic [`ICACHE_WORD_WIDTH-1:0] data_mem [`ICACHE_SETS][`ICACHE_LINE_WORDS];

        logic rd_en;
        logic wr_en;

        assign wr_en = array_req_i.way_en[w] & array_req_i.we;
        assign rd_en = array_req_i.way_en[w] & ~array_req_i.we;

        // write path, tag entry plus the single word picked by woff
        always_ff @(posedge clk_i) begin
            if (wr_en) begin
                tag_mem[array_req_i.index] <= array_req_i.wtag;
                data_mem[array_req_i.index][array_req_i.woff] <= array_req_i.wdata;
            end
        end

        // tag read port, cleared so no way looks valid out of reset
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                tag_rdata_o[w] <= '0;
            end else if (rd_en) begin
                tag_rdata_o[w] <= tag_mem[array_req_i.index];
            end
        end

        // full line read, word select happens in the lookup
        always_ff @(posedge clk_i) begin
            if (rd_en) begin
                for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
                    line_rdata_o[w][k] <= data_mem[array_req_i.index][k];
                end
            end
        end
    end

endmodule

// File: rtl/icache_pkg.sv
// -------------------------------------------------------------------------
// Instruction cache types
// -------------------------------------------------------------------------

`include "icache_config.svh"

package icache_pkg;

    // controller states
    typedef enum logic [2:0] {
        FLUSH,
        IDLE,
        TAG_CMP,
        REFILL,
        REDO_REQ,
        TAG_CMP_SAVED
    } ctrl_state_e;

    // one tag RAM entry
    typedef struct packed {
        logic                        valid;
        logic [`ICACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    // one cycle of array access, shared by flush, refill and lookup
    typedef struct packed {
        logic [`ICACHE_WAYS-1:0]               way_en;
        logic                                  we;
        logic [`ICACHE_INDEX_BITS-1:0]         index;
        tag_entry_t                            wtag;
        logic [`ICACHE_WORD_WIDTH-1:0]         wdata;
        logic [$clog2(`ICACHE_LINE_WORDS)-1:0] woff;
    } array_req_t;

    // fetch port
    typedef struct packed {
        logic                          req;
        logic [`ICACHE_ADDR_WIDTH-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic                          ready;
        logic                          valid;
        logic [`ICACHE_WORD_WIDTH-1:0] data;
    } fetch_rsp_t;

    // refill memory port
    typedef struct packed {
        logic                          req;
        logic [`ICACHE_ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                          gnt;
        logic                          rvalid;
        logic [`ICACHE_WORD_WIDTH-1:0] rdata;
    } mem_rsp_t;

endpackage

// File: rtl/icache_config.svh
// -------------------------------------------------------------------------
// Instruction cache geometry
// -------------------------------------------------------------------------

`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// associativity and number of sets
`define ICACHE_WAYS        4
`define ICACHE_SETS        16

// 32-bit words per line, also the refill burst length
`define ICACHE_LINE_WORDS  4

// byte address and data widths
`define ICACHE_ADDR_WIDTH  32
`define ICACHE_WORD_WIDTH  32

// address split: tag | index | byte offset within the line
`define ICACHE_INDEX_BITS  $clog2(`ICACHE_SETS)
`define ICACHE_OFFSET_BITS $clog2(`ICACHE_LINE_WORDS * (`ICACHE_WORD_WIDTH / 8))
`define ICACHE_TAG_BITS    (`ICACHE_ADDR_WIDTH - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

`endif
